// ==== verilog/mem_bus_pkg.sv ====
// Memory bus widths, address map, target indices and command/response structs
package mem_bus_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////
  localparam int ADDR_W = 32;
  localparam int XLEN   = 32;
  localparam int MASK_W = XLEN / 8;

  //////////////////////////////////////////////////
  // Splitter targets
  //////////////////////////////////////////////////
  localparam int NUM_TGT    = 4;
  localparam int TGT_DM     = 0;
  localparam int TGT_MROM   = 1;
  localparam int TGT_QSPI   = 2;
  localparam int TGT_SYSMEM = 3;

  // Address windows, matched on bits from the region lsb upward
  // DM      0x0000_0000 .. 0x0000_0FFF
  localparam logic [ADDR_W-1:0] DM_BASE     = 32'h0000_0000;
  localparam int                DM_LSB      = 12;
  // MROM    0x0000_1000 .. 0x0000_1FFF
  localparam logic [ADDR_W-1:0] MROM_BASE   = 32'h0000_1000;
  localparam int                MROM_LSB    = 12;
  // QSPI read-only flash window, 0x2000_0000 .. 0x3FFF_FFFF
  localparam logic [ADDR_W-1:0] QSPI_BASE   = 32'h2000_0000;
  localparam int                QSPI_LSB    = 29;
  // SysMem  0x8000_0000 .. 0xFFFF_FFFF
  localparam logic [ADDR_W-1:0] SYSMEM_BASE = 32'h8000_0000;
  localparam int                SYSMEM_LSB  = 31;

  // Mask ROM geometry
  localparam int MROM_DP    = 32;
  localparam int MROM_IDX_W = 5;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic [XLEN-1:0]   wdata;
    logic [MASK_W-1:0] wmask;
  } icb_cmd_t;

  typedef struct packed {
    logic            err;
    logic [XLEN-1:0] rdata;
  } icb_rsp_t;

endpackage

// ==== verilog/icb_pingpong_buf.sv ====
// Two-entry ping-pong command buffer with a registered input ready
`timescale 1ns/10ps

module icb_pingpong_buf (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Upstream command
  input  logic                  i_cmd_valid,
  output logic                  o_cmd_ready,
  input  mem_bus_pkg::icb_cmd_t i_cmd,
  // Downstream command
  output logic                  o_cmd_valid,
  input  logic                  i_cmd_ready,
  output mem_bus_pkg::icb_cmd_t o_cmd
);

  import mem_bus_pkg::*;

  icb_cmd_t   entry_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;
  logic       pop;

  // Ready looks at the fill count only, so the downstream ready never
  // reaches the upstream port combinationally
  assign o_cmd_ready = (cnt_q != 2'd2);
  assign o_cmd_valid = (cnt_q != 2'd0);
  assign o_cmd       = entry_q[rd_ptr_q];

  assign push = i_cmd_valid & o_cmd_ready;
  assign pop  = o_cmd_valid & i_cmd_ready;

  //////////////////////////////////////////////////
  // Pointers and fill count
  //////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge i_clk) begin
    if (push) begin
      entry_q[wr_ptr_q] <= i_cmd;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // A push into a full buffer would leave the count and pointers out of step
  a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
    (cnt_q <= 2'd2) && ((cnt_q == 2'd1) == (wr_ptr_q != rd_ptr_q)));

  // Held head entry stays put under back-pressure
  a_head_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_cmd_valid && !i_cmd_ready) |=> (o_cmd_valid && $stable(o_cmd)));

endmodule

// ==== verilog/mem_icb_splitter.sv ====
// Address-decoding command splitter with one outstanding command and error response
`timescale 1ns/10ps

module mem_icb_splitter (
  input  logic                                i_clk,
  input  logic                                i_rst,
  // Upstream command
  input  logic                                i_cmd_valid,
  output logic                                o_cmd_ready,
  input  mem_bus_pkg::icb_cmd_t               i_cmd,
  // Upstream response
  output logic                                o_rsp_valid,
  input  logic                                i_rsp_ready,
  output mem_bus_pkg::icb_rsp_t               o_rsp,
  // Target command channels
  output logic [mem_bus_pkg::NUM_TGT-1:0]     o_tgt_cmd_valid,
  input  logic [mem_bus_pkg::NUM_TGT-1:0]     i_tgt_cmd_ready,
  output mem_bus_pkg::icb_cmd_t               o_tgt_cmd,
  // Target response channels
  input  logic [mem_bus_pkg::NUM_TGT-1:0]     i_tgt_rsp_valid,
  output logic [mem_bus_pkg::NUM_TGT-1:0]     o_tgt_rsp_ready,
  input  mem_bus_pkg::icb_rsp_t               i_tgt_rsp [mem_bus_pkg::NUM_TGT]
);

  import mem_bus_pkg::*;

  logic [NUM_TGT-1:0]         hit;
  logic                       unmapped;
  logic [$clog2(NUM_TGT)-1:0] hit_idx;
  logic                       cmd_fire;
  logic                       rsp_fire;

  logic                       outs_q;
  logic                       unmap_q;
  logic [$clog2(NUM_TGT)-1:0] tgt_q;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////
  always_comb begin
    hit[TGT_DM]     = (i_cmd.addr[ADDR_W-1:DM_LSB] == DM_BASE[ADDR_W-1:DM_LSB]);
    hit[TGT_MROM]   = (i_cmd.addr[ADDR_W-1:MROM_LSB] == MROM_BASE[ADDR_W-1:MROM_LSB]);
    hit[TGT_QSPI]   = (i_cmd.addr[ADDR_W-1:QSPI_LSB] == QSPI_BASE[ADDR_W-1:QSPI_LSB]);
    hit[TGT_SYSMEM] = (i_cmd.addr[ADDR_W-1:SYSMEM_LSB] == SYSMEM_BASE[ADDR_W-1:SYSMEM_LSB]);
  end

  assign unmapped = ~(|hit);

  // Windows are disjoint, at most one hit bit is set
  always_comb begin
    hit_idx = '0;
    for (int k = 0; k < NUM_TGT; k++) begin
      if (hit[k]) begin
        hit_idx = k[$clog2(NUM_TGT)-1:0];
      end
    end
  end

  //////////////////////////////////////////////////
  // Command routing
  //////////////////////////////////////////////////
  // Nothing leaves while a command is still outstanding
  assign o_tgt_cmd_valid = (i_cmd_valid & ~outs_q) ? hit : '0;
  assign o_tgt_cmd       = i_cmd;

  // Unmapped commands are swallowed here without any target
  assign o_cmd_ready = ~outs_q & (unmapped | (|(hit & i_tgt_cmd_ready)));
  assign cmd_fire    = i_cmd_valid & o_cmd_ready;
  assign rsp_fire    = o_rsp_valid & i_rsp_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      outs_q  <= 1'b0;
      unmap_q <= 1'b0;
      tgt_q   <= '0;
    end else if (cmd_fire) begin
      outs_q  <= 1'b1;
      unmap_q <= unmapped;
      tgt_q   <= hit_idx;
    end else if (rsp_fire) begin
      outs_q  <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////
  always_comb begin
    if (unmap_q) begin
      o_rsp_valid = outs_q;
      o_rsp       = icb_rsp_t'{err: 1'b1, rdata: '0};
    end else begin
      o_rsp_valid = outs_q & i_tgt_rsp_valid[tgt_q];
      o_rsp       = i_tgt_rsp[tgt_q];
    end
  end

  always_comb begin
    o_tgt_rsp_ready = '0;
    if (outs_q && !unmap_q) begin
      o_tgt_rsp_ready[tgt_q] = i_rsp_ready;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  a_tgt_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0(o_tgt_cmd_valid));

  // No target may answer, and nothing goes upstream, with no command in flight
  a_no_stray_rsp: assert property (@(posedge i_clk) disable iff (i_rst)
    !outs_q |-> (!o_rsp_valid && !(|i_tgt_rsp_valid)));

endmodule

// ==== verilog/mrom.sv ====
// 32-word mask ROM with a one-slot registered response
`timescale 1ns/10ps

module mrom (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Command
  input  logic                  i_cmd_valid,
  output logic                  o_cmd_ready,
  input  mem_bus_pkg::icb_cmd_t i_cmd,
  // Response
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output mem_bus_pkg::icb_rsp_t o_rsp
);

  import mem_bus_pkg::*;

  localparam string INIT_FILE = "verilog/mrom_init.hex";

  logic [XLEN-1:0]       rom_mem [MROM_DP];
  logic [MROM_IDX_W-1:0] rom_idx;
  logic                  accept;
  logic                  rsp_valid_q;
  icb_rsp_t              rsp_q;

  initial begin
    $readmemh(INIT_FILE, rom_mem);
  end

  // Word index only, upper bits ignored so the image mirrors through 4 KB
  assign rom_idx = i_cmd.addr[MROM_IDX_W+1:2];

  // Slot can take a new command in the cycle it drains
  assign o_cmd_ready = ~rsp_valid_q | i_rsp_ready;
  assign accept      = i_cmd_valid & o_cmd_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (i_rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Writes are refused with an error
  always_ff @(posedge i_clk) begin
    if (accept) begin
      rsp_q.err   <= ~i_cmd.read;
      rsp_q.rdata <= i_cmd.read ? rom_mem[rom_idx] : '0;
    end
  end

  assign o_rsp_valid = rsp_valid_q;
  assign o_rsp       = rsp_q;

  a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp)));

endmodule

// ==== verilog/mem_bus_top.sv ====
// Memory subsystem top level joining buffer, splitter, mask ROM and external targets
`timescale 1ns/10ps

module mem_bus_top (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Upstream master
  input  logic                  i_mem_cmd_valid,
  output logic                  o_mem_cmd_ready,
  input  mem_bus_pkg::icb_cmd_t i_mem_cmd,
  output logic                  o_mem_rsp_valid,
  input  logic                  i_mem_rsp_ready,
  output mem_bus_pkg::icb_rsp_t o_mem_rsp,
  // Debug module window
  output logic                  o_dm_cmd_valid,
  input  logic                  i_dm_cmd_ready,
  output mem_bus_pkg::icb_cmd_t o_dm_cmd,
  input  logic                  i_dm_rsp_valid,
  output logic                  o_dm_rsp_ready,
  input  mem_bus_pkg::icb_rsp_t i_dm_rsp,
  // QSPI flash, read-only window
  output logic                  o_qspi_cmd_valid,
  input  logic                  i_qspi_cmd_ready,
  output mem_bus_pkg::icb_cmd_t o_qspi_cmd,
  input  logic                  i_qspi_rsp_valid,
  output logic                  o_qspi_rsp_ready,
  input  mem_bus_pkg::icb_rsp_t i_qspi_rsp,
  // System memory
  output logic                  o_sysmem_cmd_valid,
  input  logic                  i_sysmem_cmd_ready,
  output mem_bus_pkg::icb_cmd_t o_sysmem_cmd,
  input  logic                  i_sysmem_rsp_valid,
  output logic                  o_sysmem_rsp_ready,
  input  mem_bus_pkg::icb_rsp_t i_sysmem_rsp
);

  import mem_bus_pkg::*;

  // Buffer to splitter
  logic     buf_cmd_valid;
  logic     buf_cmd_ready;
  icb_cmd_t buf_cmd;

  // Splitter target side
  logic [NUM_TGT-1:0] tgt_cmd_valid;
  logic [NUM_TGT-1:0] tgt_cmd_ready;
  icb_cmd_t           tgt_cmd;
  logic [NUM_TGT-1:0] tgt_rsp_valid;
  logic [NUM_TGT-1:0] tgt_rsp_ready;
  icb_rsp_t           tgt_rsp [NUM_TGT];

  //////////////////////////////////////////////////
  // Fabric
  //////////////////////////////////////////////////
  icb_pingpong_buf u_icb_pingpong_buf (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cmd_valid (i_mem_cmd_valid),
    .o_cmd_ready (o_mem_cmd_ready),
    .i_cmd       (i_mem_cmd),
    .o_cmd_valid (buf_cmd_valid),
    .i_cmd_ready (buf_cmd_ready),
    .o_cmd       (buf_cmd)
  );

  mem_icb_splitter u_mem_icb_splitter (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_cmd_valid     (buf_cmd_valid),
    .o_cmd_ready     (buf_cmd_ready),
    .i_cmd           (buf_cmd),
    .o_rsp_valid     (o_mem_rsp_valid),
    .i_rsp_ready     (i_mem_rsp_ready),
    .o_rsp           (o_mem_rsp),
    .o_tgt_cmd_valid (tgt_cmd_valid),
    .i_tgt_cmd_ready (tgt_cmd_ready),
    .o_tgt_cmd       (tgt_cmd),
    .i_tgt_rsp_valid (tgt_rsp_valid),
    .o_tgt_rsp_ready (tgt_rsp_ready),
    .i_tgt_rsp       (tgt_rsp)
  );

  // Internal mask ROM on its own slot
  mrom u_mrom (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cmd_valid (tgt_cmd_valid[TGT_MROM]),
    .o_cmd_ready (tgt_cmd_ready[TGT_MROM]),
    .i_cmd       (tgt_cmd),
    .o_rsp_valid (tgt_rsp_valid[TGT_MROM]),
    .i_rsp_ready (tgt_rsp_ready[TGT_MROM]),
    .o_rsp       (tgt_rsp[TGT_MROM])
  );

  //////////////////////////////////////////////////
  // External target ports
  //////////////////////////////////////////////////
  assign o_dm_cmd_valid          = tgt_cmd_valid[TGT_DM];
  assign tgt_cmd_ready[TGT_DM]   = i_dm_cmd_ready;
  assign o_dm_cmd                = tgt_cmd;
  assign tgt_rsp_valid[TGT_DM]   = i_dm_rsp_valid;
  assign o_dm_rsp_ready          = tgt_rsp_ready[TGT_DM];
  assign tgt_rsp[TGT_DM]         = i_dm_rsp;

  assign o_qspi_cmd_valid        = tgt_cmd_valid[TGT_QSPI];
  assign tgt_cmd_ready[TGT_QSPI] = i_qspi_cmd_ready;
  assign o_qspi_cmd              = tgt_cmd;
  assign tgt_rsp_valid[TGT_QSPI] = i_qspi_rsp_valid;
  assign o_qspi_rsp_ready        = tgt_rsp_ready[TGT_QSPI];
  assign tgt_rsp[TGT_QSPI]       = i_qspi_rsp;

  assign o_sysmem_cmd_valid        = tgt_cmd_valid[TGT_SYSMEM];
  assign tgt_cmd_ready[TGT_SYSMEM] = i_sysmem_cmd_ready;
  assign o_sysmem_cmd              = tgt_cmd;
  assign tgt_rsp_valid[TGT_SYSMEM] = i_sysmem_rsp_valid;
  assign o_sysmem_rsp_ready        = tgt_rsp_ready[TGT_SYSMEM];
  assign tgt_rsp[TGT_SYSMEM]       = i_sysmem_rsp;

endmodule

// ==== verification/tb_icb_target.sv ====
// Responder model for one external bus target with random ready and response delay
`timescale 1ns/10ps

module tb_icb_target #(
  parameter logic [31:0] TAG  = 32'h0,
  parameter int          SEED = 7
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_cmd_valid,
  output logic                  o_cmd_ready,
  input  mem_bus_pkg::icb_cmd_t i_cmd,
  output logic                  o_rsp_valid,
  input  logic                  i_rsp_ready,
  output mem_bus_pkg::icb_rsp_t o_rsp
);

  import mem_bus_pkg::*;

  integer     seed;
  logic       busy;
  logic [1:0] delay;

  initial begin
    seed        = SEED;
    busy        = 1'b0;
    delay       = 2'd0;
    o_cmd_ready = 1'b0;
    o_rsp_valid = 1'b0;
    o_rsp       = '0;
  end

  // Accept, wait 0 to 3 cycles, then hold the response until taken
  always @(posedge i_clk) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    if (i_rst) begin
      busy        <= 1'b0;
      delay       <= 2'd0;
      o_cmd_ready <= 1'b0;
      o_rsp_valid <= 1'b0;
    end else begin
      o_cmd_ready <= rnd[0] | rnd[1];
      if (i_cmd_valid && o_cmd_ready && !busy) begin
        busy        <= 1'b1;
        delay       <= rnd[3:2];
        o_rsp.err   <= i_cmd.addr[2];
        o_rsp.rdata <= i_cmd.addr ^ TAG;
      end else if (busy && !o_rsp_valid) begin
        if (delay == 2'd0) begin
          o_rsp_valid <= 1'b1;
        end else begin
          delay <= delay - 2'd1;
        end
      end else if (o_rsp_valid && i_rsp_ready) begin
        o_rsp_valid <= 1'b0;
        busy        <= 1'b0;
      end
    end
  end

endmodule

// ==== verification/mem_bus_tb.sv ====
// Memory bus testbench with clock, reset, stimulus, scoreboard and checking assertions
`timescale 1ns/10ps

module mem_bus_tb;

  import mem_bus_pkg::*;

  localparam int          SEED_INIT  = 7;
  localparam int          WAIT_LIMIT = 400;
  localparam int          N_RAND     = 80;
  localparam logic [31:0] DM_TAG     = 32'hD000_0D00;
  localparam logic [31:0] QSPI_TAG   = 32'h0F1A_5000;
  localparam logic [31:0] SYSMEM_TAG = 32'h5E00_00A5;
  localparam logic [2:0]  T_DM       = 3'd0;
  localparam logic [2:0]  T_MROM     = 3'd1;
  localparam logic [2:0]  T_QSPI     = 3'd2;
  localparam logic [2:0]  T_SYSMEM   = 3'd3;
  localparam logic [2:0]  T_NONE     = 3'd4;

  typedef struct packed {
    icb_cmd_t   cmd;
    logic [2:0] tgt;
    icb_rsp_t   rsp;
  } pend_t;

  logic     clk        = 1'b0;
  logic     rst        = 1'b1;
  logic     rst_d      = 1'b0;
  logic     cmd_valid  = 1'b0;
  logic     cmd_ready;
  icb_cmd_t cmd        = '0;
  logic     rsp_valid;
  logic     rsp_ready  = 1'b1;
  icb_rsp_t rsp;
  logic     rand_ready = 1'b0;

  logic     dm_cmd_valid, dm_cmd_ready, dm_rsp_valid, dm_rsp_ready;
  logic     qspi_cmd_valid, qspi_cmd_ready, qspi_rsp_valid, qspi_rsp_ready;
  logic     sysmem_cmd_valid, sysmem_cmd_ready, sysmem_rsp_valid, sysmem_rsp_ready;
  icb_cmd_t dm_cmd, qspi_cmd, sysmem_cmd;
  icb_rsp_t dm_rsp, qspi_rsp, sysmem_rsp;

  integer      seed;
  integer      rdy_seed;
  logic [31:0] rom_img [32];
  pend_t       pend_q [$];
  pend_t       head;
  logic        head_ok;
  logic        in_flight;

  always #4 clk = ~clk;

  mem_bus_top u_mem_bus_top (
    .i_clk              (clk),
    .i_rst              (rst),
    .i_mem_cmd_valid    (cmd_valid),
    .o_mem_cmd_ready    (cmd_ready),
    .i_mem_cmd          (cmd),
    .o_mem_rsp_valid    (rsp_valid),
    .i_mem_rsp_ready    (rsp_ready),
    .o_mem_rsp          (rsp),
    .o_dm_cmd_valid     (dm_cmd_valid),
    .i_dm_cmd_ready     (dm_cmd_ready),
    .o_dm_cmd           (dm_cmd),
    .i_dm_rsp_valid     (dm_rsp_valid),
    .o_dm_rsp_ready     (dm_rsp_ready),
    .i_dm_rsp           (dm_rsp),
    .o_qspi_cmd_valid   (qspi_cmd_valid),
    .i_qspi_cmd_ready   (qspi_cmd_ready),
    .o_qspi_cmd         (qspi_cmd),
    .i_qspi_rsp_valid   (qspi_rsp_valid),
    .o_qspi_rsp_ready   (qspi_rsp_ready),
    .i_qspi_rsp         (qspi_rsp),
    .o_sysmem_cmd_valid (sysmem_cmd_valid),
    .i_sysmem_cmd_ready (sysmem_cmd_ready),
    .o_sysmem_cmd       (sysmem_cmd),
    .i_sysmem_rsp_valid (sysmem_rsp_valid),
    .o_sysmem_rsp_ready (sysmem_rsp_ready),
    .i_sysmem_rsp       (sysmem_rsp)
  );

  tb_icb_target #(.TAG(DM_TAG), .SEED(SEED_INIT + 2)) u_dm_target (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_cmd_valid (dm_cmd_valid),
    .o_cmd_ready (dm_cmd_ready),
    .i_cmd       (dm_cmd),
    .o_rsp_valid (dm_rsp_valid),
    .i_rsp_ready (dm_rsp_ready),
    .o_rsp       (dm_rsp)
  );

  tb_icb_target #(.TAG(QSPI_TAG), .SEED(SEED_INIT + 3)) u_qspi_target (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_cmd_valid (qspi_cmd_valid),
    .o_cmd_ready (qspi_cmd_ready),
    .i_cmd       (qspi_cmd),
    .o_rsp_valid (qspi_rsp_valid),
    .i_rsp_ready (qspi_rsp_ready),
    .o_rsp       (qspi_rsp)
  );

  tb_icb_target #(.TAG(SYSMEM_TAG), .SEED(SEED_INIT + 4)) u_sysmem_target (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_cmd_valid (sysmem_cmd_valid),
    .o_cmd_ready (sysmem_cmd_ready),
    .i_cmd       (sysmem_cmd),
    .o_rsp_valid (sysmem_rsp_valid),
    .i_rsp_ready (sysmem_rsp_ready),
    .o_rsp       (sysmem_rsp)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [2:0] target_of(logic [31:0] addr);
    if (addr[31]) return T_SYSMEM;
    if (addr[31:29] == 3'b001) return T_QSPI;
    if (addr[31:12] == 20'h00001) return T_MROM;
    if (addr[31:12] == 20'h00000) return T_DM;
    return T_NONE;
  endfunction

  // Unmapped addresses and ROM writes both give err 1 with zero data
  function automatic icb_rsp_t predict(icb_cmd_t c, logic [2:0] t);
    icb_rsp_t r;
    r = icb_rsp_t'{err: 1'b1, rdata: '0};
    case (t)
      T_DM:     r = icb_rsp_t'{err: c.addr[2], rdata: c.addr ^ DM_TAG};
      T_QSPI:   r = icb_rsp_t'{err: c.addr[2], rdata: c.addr ^ QSPI_TAG};
      T_SYSMEM: r = icb_rsp_t'{err: c.addr[2], rdata: c.addr ^ SYSMEM_TAG};
      T_MROM: begin
        if (c.read) begin
          r = icb_rsp_t'{err: 1'b0, rdata: rom_img[c.addr[6:2]]};
        end
      end
      default: ;
    endcase
    return r;
  endfunction

  function automatic pend_t make_entry(icb_cmd_t c);
    pend_t e;
    e.cmd = c;
    e.tgt = target_of(c.addr);
    e.rsp = predict(c, e.tgt);
    return e;
  endfunction

  function automatic icb_cmd_t mk_cmd(logic [31:0] a, logic rd, logic [31:0] wd, logic [3:0] wm);
    icb_cmd_t c;
    c.addr  = a;
    c.read  = rd;
    c.wdata = wd;
    c.wmask = wm;
    return c;
  endfunction

  // Window picked first, then a word address inside it
  function automatic icb_cmd_t random_cmd();
    logic [31:0] r;
    logic [31:0] a;
    icb_cmd_t    c;
    r = $random(seed);
    a = $random(seed);
    case (r[2:0])
      3'd0:       c.addr = {20'h00000, a[11:2], 2'b00};
      3'd1, 3'd2: c.addr = {20'h00001, a[11:2], 2'b00};
      3'd3:       c.addr = {3'b001, a[28:2], 2'b00};
      3'd4, 3'd5: c.addr = {1'b1, a[30:2], 2'b00};
      3'd6:       c.addr = {3'b010, a[28:2], 2'b00};
      default:    c.addr = {16'h0002, a[15:2], 2'b00};
    endcase
    c.read  = r[3];
    c.wdata = $random(seed);
    c.wmask = r[7:4];
    return c;
  endfunction

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rst) begin
      pend_q.delete();
      head_ok   <= 1'b0;
      head      <= '0;
      in_flight <= 1'b0;
    end else begin
      if (rsp_valid && rsp_ready && pend_q.size() != 0) begin
        void'(pend_q.pop_front());
      end
      if (cmd_valid && cmd_ready) begin
        pend_q.push_back(make_entry(cmd));
      end
      head_ok <= (pend_q.size() != 0);
      if (pend_q.size() != 0) begin
        head <= pend_q[0];
      end
      if (rsp_valid && rsp_ready) begin
        in_flight <= 1'b0;
      end else if ((dm_cmd_valid && dm_cmd_ready) || (qspi_cmd_valid && qspi_cmd_ready) ||
                   (sysmem_cmd_valid && sysmem_cmd_ready)) begin
        in_flight <= 1'b1;
      end
    end
  end

  // Upstream response ready, random only in the back-pressure phase
  always @(posedge clk) begin
    if (rand_ready) begin
      rsp_ready <= (($random(rdy_seed) & 32'h3) != 0);
    end else begin
      rsp_ready <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    abort_run($sformatf("Fail at time %0t: %s", $time, what));
  endtask

  // Reset delayed by one edge, low before the first reset edge
  always @(posedge clk) begin
    rst_d <= rst;
  end

  a_reset_quiet: assert property (@(posedge clk) rst_d |->
    (!(rsp_valid || dm_cmd_valid || qspi_cmd_valid || sysmem_cmd_valid) && cmd_ready))
    else report_mismatch("bus active during or right after reset");

  a_rsp_match: assert property (@(posedge clk) disable iff (rst)
    (rsp_valid && rsp_ready) |-> (head_ok && rsp == head.rsp))
    else report_mismatch($sformatf("response %h differs from expected %h", rsp, head.rsp));

  a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else report_mismatch("held response changed under back-pressure");

  a_dm_route: assert property (@(posedge clk) disable iff (rst)
    dm_cmd_valid |-> (head_ok && head.tgt == T_DM && dm_cmd == head.cmd))
    else report_mismatch($sformatf("wrong command at DM, addr %h", dm_cmd.addr));

  a_qspi_route: assert property (@(posedge clk) disable iff (rst)
    qspi_cmd_valid |-> (head_ok && head.tgt == T_QSPI && qspi_cmd == head.cmd))
    else report_mismatch($sformatf("wrong command at QSPI, addr %h", qspi_cmd.addr));

  a_sysmem_route: assert property (@(posedge clk) disable iff (rst)
    sysmem_cmd_valid |-> (head_ok && head.tgt == T_SYSMEM && sysmem_cmd == head.cmd))
    else report_mismatch($sformatf("wrong command at SysMem, addr %h", sysmem_cmd.addr));

  a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
    in_flight |-> !(dm_cmd_valid || qspi_cmd_valid || sysmem_cmd_valid))
    else report_mismatch("second command issued before the response transfer");

  // Upstream ready goes only to the external target whose command is in flight
  a_rsp_ready_steer: assert property (@(posedge clk) disable iff (rst)
    {dm_rsp_ready, qspi_rsp_ready, sysmem_rsp_ready} == ((in_flight && rsp_ready) ?
      {head.tgt == T_DM, head.tgt == T_QSPI, head.tgt == T_SYSMEM} : 3'b000))
    else report_mismatch("response ready steered to the wrong target");

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  task automatic send_cmd(input icb_cmd_t c);
    int n;
    n = 0;
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(posedge clk);
    while (!cmd_ready) begin
      if (n == WAIT_LIMIT) begin
        abort_run("Timeout: the command port never accepted a command");
      end
      n++;
      @(posedge clk);
    end
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    // Scoreboard holds the last accepted command after this edge
    @(posedge clk);
    while (pend_q.size() != 0) begin
      if (n == WAIT_LIMIT) begin
        abort_run("Timeout: responses still missing after the wait limit");
      end
      n++;
      @(posedge clk);
    end
    // Checks on the last response settle by the next edge
    @(posedge clk);
  endtask

  initial begin
    seed     = SEED_INIT;
    rdy_seed = SEED_INIT + 1;
    $readmemh("verilog/mrom_init.hex", rom_img);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // ROM reads, mirrored reads and a refused write
    send_cmd(mk_cmd(32'h0000_1000, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h0000_1004, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h0000_107C, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h0000_1F84, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h0000_10A0, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h0000_1008, 1'b0, 32'hCAFE_F00D, 4'hF));
    // External windows
    send_cmd(mk_cmd(32'h0000_0010, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h0000_0FFC, 1'b0, 32'h1234_5678, 4'h3));
    send_cmd(mk_cmd(32'h2000_0104, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h3FFF_FFF8, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h8000_0008, 1'b0, 32'hA5A5_0F0F, 4'hC));
    send_cmd(mk_cmd(32'hFFFF_FFFC, 1'b1, 32'h0, 4'h0));
    // Unmapped holes
    send_cmd(mk_cmd(32'h0002_0000, 1'b1, 32'h0, 4'h0));
    send_cmd(mk_cmd(32'h4000_0000, 1'b0, 32'hFFFF_FFFF, 4'hF));
    wait_drain();
    // Random traffic with upstream back-pressure
    rand_ready <= 1'b1;
    repeat (N_RAND) begin
      send_cmd(random_cmd());
    end
    wait_drain();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/mem_bus_pkg.sv
verilog/icb_pingpong_buf.sv
verilog/mem_icb_splitter.sv
verilog/mrom.sv
verilog/mem_bus_top.sv
verification/tb_icb_target.sv
verification/mem_bus_tb.sv

// ==== verilog/mrom_init.hex ====
// One 32-bit ROM word per line, word index 0 to 31
00FFA500
01FEA507
02FDA50E
03FCA515
04FBA51C
05FAA523
06F9A52A
07F8A531
08F7A538
09F6A53F
0AF5A546
0BF4A54D
0CF3A554
0DF2A55B
0EF1A562
0FF0A569
10EFA570
11EEA577
12EDA57E
13ECA585
14EBA58C
15EAA593
16E9A59A
17E8A5A1
18E7A5A8
19E6A5AF
1AE5A5B6
1BE4A5BD
1CE3A5C4
1DE2A5CB
1EE1A5D2
1FE0A5D9
